//--- Makefile
# Verilator build and run for the rename checkpoint testbench.

VERILATOR ?= verilator
TOP ?= rename_ckpt_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= TESTS PASSED

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/rename_ckpt_tb.sv
`default_nettype none

module rename_ckpt_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_BR = 4;
	localparam int NUM_ARCH = rn_pkg::NUM_ARCH;
	localparam int NUM_PHYS = rn_pkg::NUM_PHYS;
	localparam int RANDOM_CYCLES = 200;
	// Upper bound on the clock cycles used by all tests, reset included.
	localparam int TEST_CYCLES = 320;

	logic clk;
	logic rst;
	rn_pkg::rn_req_t req;
	rn_pkg::rn_rsp_t rsp;
	logic resolve_valid;
	logic resolve_correct;
	logic [NUM_BR-1:0] resolve_tag;
	logic [NUM_BR-1:0] br_tag;
	logic full;

	// Reference state.
	rn_pkg::preg_t m_map [NUM_ARCH];
	rn_pkg::preg_t m_head;
	logic [NUM_BR-1:0] m_mask;
	logic [NUM_BR-1:0] m_saved [NUM_BR];
	// Map and head captured when each tag was handed out.
	rn_pkg::preg_t c_map [NUM_BR][NUM_ARCH];
	rn_pkg::preg_t c_head [NUM_BR];

	logic [31:0] lcg_state;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	rename_ckpt_top #(
		.NUM_BR (NUM_BR)
	) uut (
		.clk (clk),
		.rst (rst),
		.req_i (req),
		.rsp_o (rsp),
		.resolve_valid_i (resolve_valid),
		.resolve_correct_i (resolve_correct),
		.resolve_tag_i (resolve_tag),
		.br_tag_o (br_tag),
		.full_o (full)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		// Upper bits, the low ones cycle too fast.
		return {16'd0, lcg_state[30:15]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int base);
		tests++;
		$display("%s: %s, %0d errors", name, (errors == base) ? "ok" : "failed", errors - base);
	endtask

	function automatic rn_pkg::rn_req_t make_req(input logic v, input logic br,
			input int dst, input int src);
		rn_pkg::rn_req_t r;
		r.valid = v;
		r.is_branch = br;
		r.dst_arch = rn_pkg::areg_t'(dst);
		r.src_arch = rn_pkg::areg_t'(src);
		return r;
	endfunction

	// Lowest clear bit as one-hot, zero when all are set.
	function automatic logic [NUM_BR-1:0] lowest_free(input logic [NUM_BR-1:0] mask);
		for (int i = 0; i < NUM_BR; i++) begin
			if (!mask[i]) begin
				return NUM_BR'(1) << i;
			end
		end
		return '0;
	endfunction

	function automatic int onehot_index(input logic [NUM_BR-1:0] v);
		for (int i = 0; i < NUM_BR; i++) begin
			if (v[i]) begin
				return i;
			end
		end
		return 0;
	endfunction

	// Picks one live tag, chosen by a random value.
	function automatic logic [NUM_BR-1:0] pick_live(input logic [31:0] r);
		int count;
		int k;
		count = $countones(m_mask);
		k = int'(r % 32'(count));
		for (int i = 0; i < NUM_BR; i++) begin
			if (m_mask[i]) begin
				if (k == 0) begin
					return NUM_BR'(1) << i;
				end
				k--;
			end
		end
		return '0;
	endfunction

	task automatic model_reset();
		for (int a = 0; a < NUM_ARCH; a++) begin
			m_map[a] = rn_pkg::preg_t'(a);
		end
		m_head = rn_pkg::preg_t'(NUM_ARCH);
		m_mask = '0;
	endtask

	// One clock cycle: drive, check the combinational outputs, step the model.
	task automatic drive_cycle(input rn_pkg::rn_req_t rq, input logic rv, input logic rc,
			input logic [NUM_BR-1:0] rt);
		logic [NUM_BR-1:0] cleared;
		logic [NUM_BR-1:0] exp_tag;
		logic exp_full;
		int t;
		req = rq;
		resolve_valid = rv;
		resolve_correct = rc;
		resolve_tag = rt;
		#10;
		// Correct resolution frees its bit before allocation.
		cleared = (rv && rc) ? (m_mask & ~rt) : m_mask;
		exp_full = &cleared;
		exp_tag = lowest_free(cleared);
		check_value("rsp_o.dst_preg", m_head, rsp.dst_preg);
		check_value("rsp_o.old_preg", m_map[rq.dst_arch], rsp.old_preg);
		check_value("rsp_o.src_preg", m_map[rq.src_arch], rsp.src_preg);
		check_value("br_tag_o", exp_tag, br_tag);
		check_value("full_o", exp_full, full);
		if (rv && !rc) begin
			// Roll back to the mispredicted branch.
			t = onehot_index(rt);
			for (int a = 0; a < NUM_ARCH; a++) begin
				m_map[a] = c_map[t][a];
			end
			m_head = c_head[t];
			m_mask = m_saved[t];
		end else begin
			if (rv && rc) begin
				for (int i = 0; i < NUM_BR; i++) begin
					m_saved[i] = m_saved[i] & ~rt;
				end
			end
			m_mask = cleared;
			// Dropped when full.
			if (rq.valid && rq.is_branch && !exp_full) begin
				t = onehot_index(exp_tag);
				m_saved[t] = cleared;
				for (int a = 0; a < NUM_ARCH; a++) begin
					c_map[t][a] = m_map[a];
				end
				c_head[t] = m_head;
				m_mask = cleared | exp_tag;
			end
			if (rq.valid && !rq.is_branch) begin
				m_map[rq.dst_arch] = m_head;
				m_head = (m_head == rn_pkg::preg_t'(NUM_PHYS - 1)) ?
					rn_pkg::preg_t'(NUM_ARCH) : m_head + rn_pkg::preg_t'(1);
			end
		end
		@(posedge clk);
		#5;
	endtask

	task automatic lookup_all();
		for (int a = 0; a < NUM_ARCH; a++) begin
			drive_cycle(make_req(1'b0, 1'b0, a, a), 1'b0, 1'b0, '0);
		end
	endtask

	task automatic rename_random(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = lcg_next();
			drive_cycle(make_req(1'b1, 1'b0, int'(r[2:0]), int'(r[5:3])), 1'b0, 1'b0, '0);
		end
	endtask

	task automatic dispatch_branch();
		drive_cycle(make_req(1'b1, 1'b1, 0, 0), 1'b0, 1'b0, '0);
	endtask

	// Resolves every live tag correctly, lowest first.
	task automatic drain_mask();
		while (m_mask != '0) begin
			drive_cycle(make_req(1'b0, 1'b0, 0, 0), 1'b1, 1'b1, m_mask & (~m_mask + 1'b1));
		end
	endtask

	task automatic test_reset();
		int base;
		base = errors;
		// Identity map, head at NUM_ARCH, tag 0 free.
		lookup_all();
		report_test("reset state", base);
	endtask

	task automatic test_renames();
		int base;
		base = errors;
		// More renames than the pool holds, so the head wraps.
		rename_random(20);
		lookup_all();
		report_test("plain renames", base);
	endtask

	task automatic test_alloc();
		int base;
		base = errors;
		for (int i = 0; i < NUM_BR; i++) begin
			dispatch_branch();
		end
		// This one is dropped.
		dispatch_branch();
		rename_random(1);
		drain_mask();
		report_test("tag allocation", base);
	endtask

	task automatic test_correct();
		int base;
		base = errors;
		dispatch_branch();
		// Renames after tag 0 so that its reuse needs a new snapshot.
		rename_random(2);
		dispatch_branch();
		dispatch_branch();
		// Free the middle tag, then reuse it.
		drive_cycle(make_req(1'b0, 1'b0, 0, 0), 1'b1, 1'b1, 4'b0010);
		dispatch_branch();
		// Same cycle: clear tag 0 and take it again.
		drive_cycle(make_req(1'b1, 1'b1, 0, 0), 1'b1, 1'b1, 4'b0001);
		rename_random(3);
		// Tag 0 is the youngest now and restores the state seen at its reuse.
		drive_cycle(make_req(1'b0, 1'b0, 0, 0), 1'b1, 1'b0, 4'b0001);
		lookup_all();
		drain_mask();
		report_test("correct resolution", base);
	endtask

	task automatic test_wrong();
		int base;
		base = errors;
		rename_random(3);
		dispatch_branch();
		rename_random(3);
		dispatch_branch();
		rename_random(3);
		dispatch_branch();
		rename_random(3);
		// Mispredict the middle branch.
		drive_cycle(make_req(1'b0, 1'b0, 0, 0), 1'b1, 1'b0, 4'b0010);
		lookup_all();
		// Oldest branch still holds tag 0.
		check_value("br_tag_o after recovery", 4'b0010, br_tag);
		check_value("full_o after recovery", 1'b0, full);
		dispatch_branch();
		dispatch_branch();
		drain_mask();
		report_test("wrong resolution", base);
	endtask

	task automatic test_random();
		int base;
		logic [31:0] r;
		base = errors;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			r = lcg_next();
			if (m_mask != '0 && r[2:0] == 3'd0) begin
				drive_cycle(make_req(1'b0, 1'b0, 0, 0), 1'b1, 1'b0, pick_live(lcg_next()));
			end else if (m_mask != '0 && r[2:0] <= 3'd2) begin
				// Correct resolution next to a plain rename only.
				drive_cycle(make_req(r[3], 1'b0, int'(r[6:4]), int'(r[9:7])), 1'b1, 1'b1,
					pick_live(lcg_next()));
			end else begin
				drive_cycle(make_req(r[3], r[5:4] == 2'b00, int'(r[8:6]), int'(r[11:9])),
					1'b0, 1'b0, '0);
			end
		end
		drain_mask();
		report_test("random mix", base);
	endtask

	initial begin
		lcg_state = 32'd30;
		rst = 1'b1;
		req = '0;
		resolve_valid = 1'b0;
		resolve_correct = 1'b0;
		resolve_tag = '0;
		model_reset();
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
		test_reset();
		test_renames();
		test_alloc();
		test_correct();
		test_wrong();
		test_random();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		#((TEST_CYCLES + 100) * 100);
		$display("TIMEOUT: tests did not finish within %0d cycles", TEST_CYCLES + 100);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/br_mask_ctrl.sv
`default_nettype none

module br_mask_ctrl #(
	parameter int NUM_BR = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire rn_pkg::rn_req_t dispatch_i,
	input wire logic resolve_valid_i,
	input wire logic resolve_correct_i,
	input wire logic [NUM_BR-1:0] resolve_tag_i,
	output logic [NUM_BR-1:0] br_mask_o,
	output logic [NUM_BR-1:0] br_tag_o,
	output logic full_o
);

	// Live branch mask, one bit per branch in flight.
	logic [NUM_BR-1:0] br_mask;
	// Mask seen at dispatch of each tag, without the tag's own bit.
	logic [NUM_BR-1:0] saved_mask [NUM_BR];
	logic [NUM_BR-1:0] mask_cleared;
	logic [NUM_BR-1:0] free_tag;
	logic [NUM_BR-1:0] saved_sel;
	logic resolve_ok;
	logic recover;
	logic branch_go;

	assign resolve_ok = resolve_valid_i & resolve_correct_i;
	assign recover = resolve_valid_i & ~resolve_correct_i;

	// A correct resolution frees its bit before allocation looks.
	assign mask_cleared = resolve_ok ? (br_mask & ~resolve_tag_i) : br_mask;

	// Lowest clear bit, as a one-hot vector.
	// Comes out zero when every bit is taken.
	assign free_tag = ~mask_cleared & (mask_cleared + NUM_BR'(1));

	assign full_o = &mask_cleared;
	assign br_tag_o = free_tag;
	// Stack entries see a correctly resolved bit as free already.
	// A tag reused in the same cycle then takes a fresh snapshot.
	assign br_mask_o = mask_cleared;

	// A branch seen while full is dropped.
	assign branch_go = dispatch_i.valid & dispatch_i.is_branch & ~full_o;

	// Pick the saved mask of the mispredicted tag.
	always_comb begin
		saved_sel = '0;
		for (int i = 0; i < NUM_BR; i++) begin
			if (resolve_tag_i[i]) begin
				saved_sel |= saved_mask[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			br_mask <= '0;
		end else if (recover) begin
			// Younger branches vanish along with the wrong one.
			br_mask <= saved_sel;
		end else if (branch_go) begin
			br_mask <= mask_cleared | free_tag;
		end else begin
			br_mask <= mask_cleared;
		end
	end

	// Saved masks only matter while their tag is live.
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_BR; i++) begin
			if (branch_go && free_tag[i]) begin
				saved_mask[i] <= mask_cleared;
			end else if (resolve_ok) begin
				// A resolved older branch must not come back on recovery.
				saved_mask[i] <= saved_mask[i] & ~resolve_tag_i;
			end
		end
	end

	a_tag_live: assert property (@(posedge clk) disable iff (rst)
		resolve_valid_i |-> ($onehot(resolve_tag_i) && ((resolve_tag_i & br_mask) != '0)))
		else $error("resolve tag not one-hot or not in flight");

	// Recovery owns the cycle.
	a_no_disp_rec: assert property (@(posedge clk) disable iff (rst)
		recover |-> !dispatch_i.valid)
		else $error("dispatch during wrong resolution");

endmodule

`default_nettype wire

//--- src/br_stack.sv
`default_nettype none

module br_stack #(
	parameter int NUM_BR = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [NUM_BR-1:0] br_mask_i,
	input wire rn_pkg::ckpt_t ckpt_next_i,
	input wire logic [NUM_BR-1:0] resolve_tag_i,
	output rn_pkg::ckpt_t ckpt_restore_o
);

	// Per-tag snapshots.
	rn_pkg::ckpt_t ent_q [NUM_BR];

	// One entry per mask bit.
	for (genvar g = 0; g < NUM_BR; g++) begin : g_ent
		br_stack_ent u_ent (
			.clk (clk),
			.rst (rst),
			.mask_bit_i (br_mask_i[g]),
			.bak_i (ckpt_next_i),
			.rc_o (ent_q[g])
		);
	end

	// One-hot select by OR.
	// An all-zero tag gives an all-zero snapshot.
	always_comb begin
		ckpt_restore_o = '0;
		for (int i = 0; i < NUM_BR; i++) begin
			if (resolve_tag_i[i]) begin
				ckpt_restore_o |= ent_q[i];
			end
		end
	end

	// Two set bits would blend two snapshots.
	a_tag_onehot: assert property (@(posedge clk) disable iff (rst)
		(resolve_tag_i != '0) |-> $onehot(resolve_tag_i))
		else $error("restore select is not one-hot");

endmodule

`default_nettype wire

//--- src/br_stack_ent.sv
`default_nettype none

module br_stack_ent (
	input wire logic clk,
	input wire logic rst,
	input wire logic mask_bit_i,
	input wire rn_pkg::ckpt_t bak_i,
	output rn_pkg::ckpt_t rc_o
);

	// Stored snapshot.
	rn_pkg::ckpt_t snap;

	// Free entry keeps shadowing the next state.
	// Once the bit is set the copy made at that edge is kept.
	always_ff @(posedge clk) begin
		if (rst) begin
			snap <= '0;
		end else if (!mask_bit_i) begin
			snap <= bak_i;
		end
	end

	assign rc_o = snap;

endmodule

`default_nettype wire

//--- src/rename_ckpt_top.sv
`default_nettype none

module rename_ckpt_top #(
	parameter int NUM_BR = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire rn_pkg::rn_req_t req_i,
	output rn_pkg::rn_rsp_t rsp_o,
	input wire logic resolve_valid_i,
	input wire logic resolve_correct_i,
	input wire logic [NUM_BR-1:0] resolve_tag_i,
	output logic [NUM_BR-1:0] br_tag_o,
	output logic full_o
);

	// Mask bits freeze the matching stack entries.
	logic [NUM_BR-1:0] br_mask;
	// Next rename state, tracked by free entries.
	rn_pkg::ckpt_t ckpt_next;
	// Snapshot picked by the resolve tag.
	rn_pkg::ckpt_t ckpt_restore;
	logic recover;

	// Only a wrong resolution rolls the map back.
	assign recover = resolve_valid_i & ~resolve_correct_i;

	br_mask_ctrl #(
		.NUM_BR (NUM_BR)
	) u_mask (
		.clk (clk),
		.rst (rst),
		.dispatch_i (req_i),
		.resolve_valid_i (resolve_valid_i),
		.resolve_correct_i (resolve_correct_i),
		.resolve_tag_i (resolve_tag_i),
		.br_mask_o (br_mask),
		.br_tag_o (br_tag_o),
		.full_o (full_o)
	);

	br_stack #(
		.NUM_BR (NUM_BR)
	) u_stack (
		.clk (clk),
		.rst (rst),
		.br_mask_i (br_mask),
		.ckpt_next_i (ckpt_next),
		.resolve_tag_i (resolve_tag_i),
		.ckpt_restore_o (ckpt_restore)
	);

	rename_map u_map (
		.clk (clk),
		.rst (rst),
		.req_i (req_i),
		.rsp_o (rsp_o),
		.recover_i (recover),
		.ckpt_restore_i (ckpt_restore),
		.ckpt_next_o (ckpt_next)
	);

endmodule

`default_nettype wire

//--- src/rename_map.sv
`default_nettype none

module rename_map (
	input wire logic clk,
	input wire logic rst,
	input wire rn_pkg::rn_req_t req_i,
	output rn_pkg::rn_rsp_t rsp_o,
	input wire logic recover_i,
	input wire rn_pkg::ckpt_t ckpt_restore_i,
	output rn_pkg::ckpt_t ckpt_next_o
);

	// Current map table and free-list head.
	rn_pkg::ckpt_t state_q;
	// State after this cycle's rename, before recovery.
	rn_pkg::ckpt_t renamed;
	rn_pkg::ckpt_t state_n;
	rn_pkg::preg_t head_inc;
	logic do_rename;

	// Branches carry no destination.
	assign do_rename = req_i.valid & ~req_i.is_branch;

	// Head walks the rename pool above the architectural names.
	// After the top register it wraps back to NUM_ARCH.
	assign head_inc = (state_q.fl_head == rn_pkg::preg_t'(rn_pkg::NUM_PHYS - 1)) ?
		rn_pkg::preg_t'(rn_pkg::NUM_ARCH) : state_q.fl_head + 1'b1;

	// Lookups read the current table only.
	assign rsp_o = '{
		dst_preg: state_q.fl_head,
		old_preg: state_q.map[req_i.dst_arch],
		src_preg: state_q.map[req_i.src_arch]
	};

	always_comb begin
		renamed = state_q;
		if (do_rename) begin
			renamed.map[req_i.dst_arch] = state_q.fl_head;
			renamed.fl_head = head_inc;
		end
	end

	// Recovery overrides any rename.
	assign state_n = recover_i ? ckpt_restore_i : renamed;

	// Free stack entries shadow this value.
	assign ckpt_next_o = state_n;

	always_ff @(posedge clk) begin
		if (rst) begin
			// Identity map at start.
			for (int i = 0; i < rn_pkg::NUM_ARCH; i++) begin
				state_q.map[i] <= rn_pkg::preg_t'(i);
			end
			state_q.fl_head <= rn_pkg::preg_t'(rn_pkg::NUM_ARCH);
		end else begin
			state_q <= state_n;
		end
	end

	// Architectural names are never handed out by the head.
	a_head_pool: assert property (@(posedge clk) disable iff (rst)
		state_q.fl_head >= rn_pkg::preg_t'(rn_pkg::NUM_ARCH))
		else $error("free-list head left the rename pool");

endmodule

`default_nettype wire

//--- src/rn_pkg.sv
`default_nettype none

package rn_pkg;

	// Architectural register index width.
	localparam int ARCH_IDX_W = 3;
	// Physical register index width.
	localparam int PRF_IDX_W = 4;

	// Register counts follow from the index widths.
	localparam int NUM_ARCH = 1 << ARCH_IDX_W;
	localparam int NUM_PHYS = 1 << PRF_IDX_W;

	typedef logic [ARCH_IDX_W-1:0] areg_t;
	typedef logic [PRF_IDX_W-1:0] preg_t;

	// One instruction entering rename.
	// The dst_arch field is ignored for a branch.
	typedef struct packed {
		logic valid;
		logic is_branch;
		areg_t dst_arch;
		areg_t src_arch;
	} rn_req_t;

	// Physical names handed back to the issue side.
	typedef struct packed {
		preg_t dst_preg;
		preg_t old_preg;
		preg_t src_preg;
	} rn_rsp_t;

	// Snapshot of the whole rename state.
	// Map entry i holds the physical name of architectural register i.
	typedef struct packed {
		logic [NUM_ARCH-1:0][PRF_IDX_W-1:0] map;
		preg_t fl_head;
	} ckpt_t;

endpackage

`default_nettype wire

//--- vlog.f
src/rn_pkg.sv
src/br_stack_ent.sv
src/br_stack.sv
src/br_mask_ctrl.sv
src/rename_map.sv
src/rename_ckpt_top.sv
dv/rename_ckpt_tb.sv
